//--- build.f
+incdir+design
design/memPkg.sv
design/engPkg.sv
design/scratchSram.sv
design/memArbiter.sv
design/copyEngine.sv
design/fillEngine.sv
design/scratchSubsys.sv
verif/scratchSubsys_tb.sv

//--- Bender.yml
package:
  name: scratch_subsys

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/memPkg.sv
      - design/engPkg.sv
      - design/scratchSram.sv
      - design/memArbiter.sv
      - design/copyEngine.sv
      - design/fillEngine.sv
      - design/scratchSubsys.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/scratchSubsys_tb.sv

//--- verif/scratchSubsys_tb.sv
`timescale 1ns/1ns
`include "scratch_defs.svh"

module scratchSubsys_tb;

  localparam int unsigned ByteW     = `SCR_BYTE_WIDTH;
  localparam int unsigned GntLimit  = 50;
  localparam int unsigned RunLimit  = 4000;
  localparam int unsigned PeerCount = 3;

  logic          clk;
  logic          rstN;
  logic          hostReq;
  logic          hostWe;
  memPkg::addr_t hostAddr;
  memPkg::data_t hostWdata;
  memPkg::be_t   hostBe;
  logic          hostGnt;
  logic          hostRvalid;
  memPkg::data_t hostRdata;
  logic          copyStart;
  memPkg::addr_t copySrc;
  memPkg::addr_t copyDst;
  engPkg::len_t  copyLen;
  logic          copyBusy;
  logic          copyDone;
  logic          fillStart;
  memPkg::addr_t fillDst;
  engPkg::len_t  fillLen;
  memPkg::data_t fillPattern;
  logic          fillBusy;
  logic          fillDone;

  // reference copy of the scratchpad contents
  memPkg::data_t model [`SCR_NUM_WORDS];

  // done pulses seen so far
  int unsigned copyDoneCnt = 0;
  int unsigned fillDoneCnt = 0;

  // cycles the last host request spent without a grant
  int unsigned gntWait = 0;

  scratchSubsys uut (
    .clk_i        (clk),
    .rst_ni       (rstN),
    .hostReq_i    (hostReq),
    .hostWe_i     (hostWe),
    .hostAddr_i   (hostAddr),
    .hostWdata_i  (hostWdata),
    .hostBe_i     (hostBe),
    .hostGnt_o    (hostGnt),
    .hostRvalid_o (hostRvalid),
    .hostRdata_o  (hostRdata),
    .copyStart_i  (copyStart),
    .copySrc_i    (copySrc),
    .copyDst_i    (copyDst),
    .copyLen_i    (copyLen),
    .copyBusy_o   (copyBusy),
    .copyDone_o   (copyDone),
    .fillStart_i  (fillStart),
    .fillDst_i    (fillDst),
    .fillLen_i    (fillLen),
    .fillPattern_i(fillPattern),
    .fillBusy_o   (fillBusy),
    .fillDone_o   (fillDone)
  );

  always #5 clk = ~clk;

  // count done pulses
  // each one lasts a single cycle
  always @(negedge clk) begin
    if (copyDone) begin
      copyDoneCnt++;
    end
    if (fillDone) begin
      fillDoneCnt++;
    end
  end

  task automatic failNow(input string why);
    $display("%s (at %0t ns)", why, $time);
    $display("TEST FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic checkData(input string sig, input memPkg::data_t exp, input memPkg::data_t act);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s expected %h, got %h", $time, sig, exp, act);
      $display("TEST FAILED");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic checkFlag(input string sig, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s expected %b, got %b", $time, sig, exp, act);
      $display("TEST FAILED");
      $fatal(1, "flag mismatch");
    end
  endtask

  // byte lanes change only where enabled
  function automatic void applyWrite(memPkg::addr_t a, memPkg::data_t d, memPkg::be_t be);
    for (int b = 0; b < $bits(memPkg::be_t); b++) begin
      if (be[b]) begin
        model[a][b*ByteW +: ByteW] = d[b*ByteW +: ByteW];
      end
    end
  endfunction

  // ascending copy with addresses wrapping at the top
  function automatic void modelCopy(memPkg::addr_t src, memPkg::addr_t dst, int len);
    for (int k = 0; k < len; k++) begin
      model[memPkg::addr_t'(dst + k)] = model[memPkg::addr_t'(src + k)];
    end
  endfunction

  function automatic void modelFill(memPkg::addr_t dst, int len, memPkg::data_t pat);
    for (int k = 0; k < len; k++) begin
      model[memPkg::addr_t'(dst + k)] = pat + memPkg::data_t'(k);
    end
  endfunction

  // grant is combinational and sampled mid cycle
  task automatic waitHostGnt();
    int unsigned n;
    n = 0;
    @(negedge clk);
    while (!hostGnt && n < GntLimit) begin
      @(negedge clk);
      n++;
    end
    if (!hostGnt) failNow("host request was never granted");
    gntWait = n;
  endtask

  task automatic hostWrite(input memPkg::addr_t a, input memPkg::data_t d, input memPkg::be_t be);
    hostReq   = 1'b1;
    hostWe    = 1'b1;
    hostAddr  = a;
    hostWdata = d;
    hostBe    = be;
    waitHostGnt();
    applyWrite(a, d, be);
    @(posedge clk);
    #1;
    hostReq = 1'b0;
    hostWe  = 1'b0;
  endtask

  task automatic hostRead(input memPkg::addr_t a, output memPkg::data_t d);
    int unsigned n;
    hostReq  = 1'b1;
    hostWe   = 1'b0;
    hostAddr = a;
    hostBe   = '0;
    waitHostGnt();
    @(posedge clk);
    #1;
    hostReq = 1'b0;
    n = 0;
    @(negedge clk);
    while (!hostRvalid && n < GntLimit) begin
      @(negedge clk);
      n++;
    end
    if (!hostRvalid) failNow("host read never returned data");
    d = hostRdata;
    // exactly one pulse per read
    @(negedge clk);
    checkFlag("hostRvalid_o", 1'b0, hostRvalid);
    @(posedge clk);
    #1;
  endtask

  task automatic checkWord(input memPkg::addr_t a);
    memPkg::data_t d;
    hostRead(a, d);
    checkData($sformatf("hostRdata_o @%02h", a), model[a], d);
  endtask

  task automatic checkRegion(input memPkg::addr_t base, input int len);
    for (int k = 0; k < len; k++) begin
      checkWord(memPkg::addr_t'(base + k));
    end
  endtask

  task automatic startCopy(input memPkg::addr_t src, input memPkg::addr_t dst, input int len);
    copyStart = 1'b1;
    copySrc   = src;
    copyDst   = dst;
    copyLen   = engPkg::len_t'(len);
    @(posedge clk);
    #1;
    copyStart = 1'b0;
  endtask

  task automatic startFill(input memPkg::addr_t dst, input int len, input memPkg::data_t pat);
    fillStart   = 1'b1;
    fillDst     = dst;
    fillLen     = engPkg::len_t'(len);
    fillPattern = pat;
    @(posedge clk);
    #1;
    fillStart = 1'b0;
  endtask

  task automatic waitCopyDone();
    int unsigned n;
    n = 0;
    @(negedge clk);
    while (!copyDone && n < RunLimit) begin
      @(negedge clk);
      n++;
    end
    if (!copyDone) failNow("copy engine never signalled done");
    @(posedge clk);
    #1;
  endtask

  task automatic waitFillDone();
    int unsigned n;
    n = 0;
    @(negedge clk);
    while (!fillDone && n < RunLimit) begin
      @(negedge clk);
      n++;
    end
    if (!fillDone) failNow("fill engine never signalled done");
    @(posedge clk);
    #1;
  endtask

  task automatic runCopy(input memPkg::addr_t src, input memPkg::addr_t dst, input int len);
    startCopy(src, dst, len);
    waitCopyDone();
    modelCopy(src, dst, len);
  endtask

  task automatic runFill(input memPkg::addr_t dst, input int len, input memPkg::data_t pat);
    startFill(dst, len, pat);
    waitFillDone();
    modelFill(dst, len, pat);
  endtask

  task automatic resetState();
    @(negedge clk);
    checkFlag("copyBusy_o", 1'b0, copyBusy);
    checkFlag("fillBusy_o", 1'b0, fillBusy);
    @(posedge clk);
    #1;
    checkWord(8'h00);
    checkWord(8'h01);
    checkWord(8'h7f);
    checkWord(8'hff);
  endtask

  task automatic hostByteWrites();
    memPkg::addr_t a;
    for (int i = 0; i < 24; i++) begin
      a = memPkg::addr_t'($urandom);
      hostWrite(a, memPkg::data_t'($urandom), memPkg::be_t'($urandom));
      checkWord(a);
    end
  endtask

  task automatic fillRuns();
    int unsigned c0;
    runFill(8'h40, 20, memPkg::data_t'($urandom));
    checkRegion(8'h40, 20);
    // run that crosses the top address
    runFill(8'hf8, 16, 32'hffff_fffa);
    checkRegion(8'hf8, 16);
    // empty run gives done but no writes
    c0 = fillDoneCnt;
    runFill(8'h60, 0, 32'hdead_beef);
    if (fillDoneCnt != c0 + 1) failNow("zero-length fill gave no single done pulse");
    checkRegion(8'h60, 4);
  endtask

  task automatic copyRun();
    for (int k = 0; k < 16; k++) begin
      hostWrite(memPkg::addr_t'(8'h10 + k), memPkg::data_t'($urandom), '1);
    end
    runCopy(8'h10, 8'h30, 16);
    checkRegion(8'h30, 16);
    checkRegion(8'h10, 16);
  endtask

  task automatic concurrentPeers();
    int unsigned c0;
    int unsigned f0;
    int unsigned n;
    memPkg::data_t pat;
    c0  = copyDoneCnt;
    f0  = fillDoneCnt;
    pat = memPkg::data_t'($urandom);
    // both engines kicked off in the same cycle
    copySrc     = 8'h10;
    copyDst     = 8'h90;
    copyLen     = 16;
    fillDst     = 8'h40;
    fillLen     = 32;
    fillPattern = pat;
    copyStart   = 1'b1;
    fillStart   = 1'b1;
    @(posedge clk);
    #1;
    copyStart = 1'b0;
    fillStart = 1'b0;
    // host keeps reading an untouched region meanwhile
    n = 0;
    while ((copyDoneCnt == c0 || fillDoneCnt == f0) && n < 400) begin
      checkWord(memPkg::addr_t'(8'ha0 + ($urandom % 32)));
      // round robin over three peers grants the host within three cycles
      if (gntWait >= PeerCount) failNow("host waited more than three cycles for a grant");
      n++;
    end
    if (copyDoneCnt == c0 || fillDoneCnt == f0) failNow("engines stalled under host traffic");
    modelCopy(8'h10, 8'h90, 16);
    modelFill(8'h40, 32, pat);
    checkRegion(8'h90, 16);
    checkRegion(8'h40, 32);
    checkRegion(8'h10, 16);
  endtask

  task automatic busyStartIgnored();
    int unsigned c0;
    int unsigned f0;
    c0 = copyDoneCnt;
    startCopy(8'h10, 8'hc0, 8);
    checkFlag("copyBusy_o", 1'b1, copyBusy);
    // second start lands while the copy is running
    startCopy(8'h30, 8'hd0, 4);
    waitCopyDone();
    modelCopy(8'h10, 8'hc0, 8);
    f0 = fillDoneCnt;
    startFill(8'he0, 6, 32'h1234_0000);
    checkFlag("fillBusy_o", 1'b1, fillBusy);
    startFill(8'hd8, 4, 32'h5555_5555);
    waitFillDone();
    modelFill(8'he0, 6, 32'h1234_0000);
    // watch for a stray second done
    repeat (10) @(posedge clk);
    #1;
    if (copyDoneCnt != c0 + 1) failNow("copy engine gave more than one done pulse");
    if (fillDoneCnt != f0 + 1) failNow("fill engine gave more than one done pulse");
    checkFlag("copyBusy_o", 1'b0, copyBusy);
    checkFlag("fillBusy_o", 1'b0, fillBusy);
    checkRegion(8'hc0, 8);
    checkRegion(8'hd0, 4);
    checkRegion(8'he0, 6);
    checkRegion(8'hd8, 4);
  endtask

  initial begin
    void'($urandom(25));
    clk         = 1'b0;
    rstN        = 1'b0;
    hostReq     = 1'b0;
    hostWe      = 1'b0;
    hostAddr    = '0;
    hostWdata   = '0;
    hostBe      = '0;
    copyStart   = 1'b0;
    copySrc     = '0;
    copyDst     = '0;
    copyLen     = '0;
    fillStart   = 1'b0;
    fillDst     = '0;
    fillLen     = '0;
    fillPattern = '0;
    for (int i = 0; i < `SCR_NUM_WORDS; i++) begin
      model[i] = '0;
    end
    repeat (16) @(posedge clk);
    #1;
    rstN = 1'b1;
    @(posedge clk);
    #1;
    resetState();
    hostByteWrites();
    fillRuns();
    copyRun();
    concurrentPeers();
    busyStartIgnored();
    $display("TEST OK");
    $finish;
  end

endmodule

//--- design/scratchSubsys.sv
`timescale 1ns/1ns
`include "scratch_defs.svh"

module scratchSubsys (
  input  logic          clk_i,
  input  logic          rst_ni,
  // host lane
  input  logic          hostReq_i,
  input  logic          hostWe_i,
  input  memPkg::addr_t hostAddr_i,
  input  memPkg::data_t hostWdata_i,
  input  memPkg::be_t   hostBe_i,
  output logic          hostGnt_o,
  output logic          hostRvalid_o,
  output memPkg::data_t hostRdata_o,
  // copy engine control
  input  logic          copyStart_i,
  input  memPkg::addr_t copySrc_i,
  input  memPkg::addr_t copyDst_i,
  input  engPkg::len_t  copyLen_i,
  output logic          copyBusy_o,
  output logic          copyDone_o,
  // fill engine control
  input  logic          fillStart_i,
  input  memPkg::addr_t fillDst_i,
  input  engPkg::len_t  fillLen_i,
  input  memPkg::data_t fillPattern_i,
  output logic          fillBusy_o,
  output logic          fillDone_o
);

  // arbiter slot numbers
  localparam memPkg::reqIdx_t HostIdx = 2'd0;
  localparam memPkg::reqIdx_t CopyIdx = 2'd1;
  localparam memPkg::reqIdx_t FillIdx = 2'd2;

  // requester lanes into the arbiter
  logic          [2:0] laneReq;
  logic          [2:0] laneWe;
  memPkg::addr_t [2:0] laneAddr;
  memPkg::data_t [2:0] laneWdata;
  memPkg::be_t   [2:0] laneBe;
  logic          [2:0] laneGnt;
  logic          [2:0] laneRvalid;

  // arbiter to sram
  logic          memReq;
  logic          memWe;
  memPkg::addr_t memAddr;
  memPkg::data_t memWdata;
  memPkg::be_t   memBe;
  // shared read bus
  memPkg::data_t memRdata;

  // host drives its slot directly
  assign laneReq[HostIdx]   = hostReq_i;
  assign laneWe[HostIdx]    = hostWe_i;
  assign laneAddr[HostIdx]  = hostAddr_i;
  assign laneWdata[HostIdx] = hostWdata_i;
  assign laneBe[HostIdx]    = hostBe_i;
  assign hostGnt_o          = laneGnt[HostIdx];
  assign hostRvalid_o       = laneRvalid[HostIdx];
  assign hostRdata_o        = memRdata;

  copyEngine iCopy (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (copyStart_i),
    .src_i      (copySrc_i),
    .dst_i      (copyDst_i),
    .len_i      (copyLen_i),
    .busy_o     (copyBusy_o),
    .done_o     (copyDone_o),
    .memReq_o   (laneReq[CopyIdx]),
    .memWe_o    (laneWe[CopyIdx]),
    .memAddr_o  (laneAddr[CopyIdx]),
    .memWdata_o (laneWdata[CopyIdx]),
    .memBe_o    (laneBe[CopyIdx]),
    .memGnt_i   (laneGnt[CopyIdx]),
    .memRvalid_i(laneRvalid[CopyIdx]),
    .memRdata_i (memRdata)
  );

  // fill never reads, so its rvalid lane stays unconnected here
  fillEngine iFill (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .start_i   (fillStart_i),
    .dst_i     (fillDst_i),
    .len_i     (fillLen_i),
    .pattern_i (fillPattern_i),
    .busy_o    (fillBusy_o),
    .done_o    (fillDone_o),
    .memReq_o  (laneReq[FillIdx]),
    .memWe_o   (laneWe[FillIdx]),
    .memAddr_o (laneAddr[FillIdx]),
    .memWdata_o(laneWdata[FillIdx]),
    .memBe_o   (laneBe[FillIdx]),
    .memGnt_i  (laneGnt[FillIdx])
  );

  memArbiter #(
    .NumReq(3)
  ) iArb (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (laneReq),
    .we_i      (laneWe),
    .addr_i    (laneAddr),
    .wdata_i   (laneWdata),
    .be_i      (laneBe),
    .gnt_o     (laneGnt),
    .rvalid_o  (laneRvalid),
    .memReq_o  (memReq),
    .memWe_o   (memWe),
    .memAddr_o (memAddr),
    .memWdata_o(memWdata),
    .memBe_o   (memBe)
  );

  scratchSram #(
    .NumWords (`SCR_NUM_WORDS),
    .DataWidth(`SCR_DATA_WIDTH),
    .ByteWidth(`SCR_BYTE_WIDTH),
    .Latency  (`SCR_LATENCY)
  ) iSram (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (memReq),
    .we_i   (memWe),
    .addr_i (memAddr),
    .wdata_i(memWdata),
    .be_i   (memBe),
    .rdata_o(memRdata)
  );

endmodule

//--- design/fillEngine.sv
`timescale 1ns/1ns

module fillEngine (
  input  logic          clk_i,
  input  logic          rst_ni,
  // run control
  input  logic          start_i,
  input  memPkg::addr_t dst_i,
  input  engPkg::len_t  len_i,
  input  memPkg::data_t pattern_i,
  output logic          busy_o,
  output logic          done_o,
  // requester lane, write only
  output logic          memReq_o,
  output logic          memWe_o,
  output memPkg::addr_t memAddr_o,
  output memPkg::data_t memWdata_o,
  output memPkg::be_t   memBe_o,
  input  logic          memGnt_i
);

  engPkg::fillState_t stateQ;

  memPkg::addr_t dstQ;
  engPkg::len_t  remQ;

  // pattern plus index of the current word
  memPkg::data_t dataQ;

  logic doneQ;

  assign busy_o = (stateQ == engPkg::FillWrite);
  assign done_o = doneQ;

  // write request held until granted
  assign memReq_o   = (stateQ == engPkg::FillWrite);
  assign memWe_o    = 1'b1;
  assign memAddr_o  = dstQ;
  assign memWdata_o = dataQ;
  assign memBe_o    = '1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stateQ <= engPkg::FillIdle;
      dstQ   <= '0;
      remQ   <= '0;
      dataQ  <= '0;
      doneQ  <= 1'b0;
    end else begin
      doneQ <= 1'b0;
      case (stateQ)
        engPkg::FillIdle: begin
          if (start_i) begin
            // empty run only reports done
            if (len_i == '0) begin
              doneQ <= 1'b1;
            end else begin
              dstQ   <= dst_i;
              remQ   <= len_i;
              dataQ  <= pattern_i;
              stateQ <= engPkg::FillWrite;
            end
          end
        end
        engPkg::FillWrite: begin
          if (memGnt_i) begin
            // step address and value together
            dstQ  <= dstQ + 1'b1;
            dataQ <= dataQ + 1'b1;
            remQ  <= remQ - 1'b1;
            if (remQ == engPkg::len_t'(1)) begin
              doneQ  <= 1'b1;
              stateQ <= engPkg::FillIdle;
            end
          end
        end
        default: stateQ <= engPkg::FillIdle;
      endcase
    end
  end

endmodule

//--- design/copyEngine.sv
`timescale 1ns/1ns

module copyEngine (
  input  logic          clk_i,
  input  logic          rst_ni,
  // run control
  input  logic          start_i,
  input  memPkg::addr_t src_i,
  input  memPkg::addr_t dst_i,
  input  engPkg::len_t  len_i,
  output logic          busy_o,
  output logic          done_o,
  // requester lane
  output logic          memReq_o,
  output logic          memWe_o,
  output memPkg::addr_t memAddr_o,
  output memPkg::data_t memWdata_o,
  output memPkg::be_t   memBe_o,
  input  logic          memGnt_i,
  input  logic          memRvalid_i,
  input  memPkg::data_t memRdata_i
);

  engPkg::copyState_t stateQ;

  // next source and destination words
  memPkg::addr_t srcQ;
  memPkg::addr_t dstQ;

  // words still to be written
  engPkg::len_t remQ;

  // word in transit between read and write
  memPkg::data_t dataQ;

  logic doneQ;

  assign busy_o = (stateQ != engPkg::CopyIdle);
  assign done_o = doneQ;

  // request held for as long as the state lasts
  assign memReq_o   = (stateQ == engPkg::CopyRead) || (stateQ == engPkg::CopyWrite);
  assign memWe_o    = (stateQ == engPkg::CopyWrite);
  assign memAddr_o  = (stateQ == engPkg::CopyWrite) ? dstQ : srcQ;
  assign memWdata_o = dataQ;
  // whole words are copied
  assign memBe_o    = '1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stateQ <= engPkg::CopyIdle;
      srcQ   <= '0;
      dstQ   <= '0;
      remQ   <= '0;
      dataQ  <= '0;
      doneQ  <= 1'b0;
    end else begin
      // done lasts a single cycle
      doneQ <= 1'b0;
      case (stateQ)
        engPkg::CopyIdle: begin
          // start only seen here, so a busy engine ignores it
          if (start_i) begin
            if (len_i == '0) begin
              doneQ <= 1'b1;
            end else begin
              srcQ   <= src_i;
              dstQ   <= dst_i;
              remQ   <= len_i;
              stateQ <= engPkg::CopyRead;
            end
          end
        end
        engPkg::CopyRead: begin
          if (memGnt_i) begin
            // ascending order, wraps at the top address
            srcQ   <= srcQ + 1'b1;
            stateQ <= engPkg::CopyWaitData;
          end
        end
        engPkg::CopyWaitData: begin
          if (memRvalid_i) begin
            dataQ  <= memRdata_i;
            stateQ <= engPkg::CopyWrite;
          end
        end
        engPkg::CopyWrite: begin
          if (memGnt_i) begin
            dstQ <= dstQ + 1'b1;
            remQ <= remQ - 1'b1;
            // last word written ends the run
            if (remQ == engPkg::len_t'(1)) begin
              doneQ  <= 1'b1;
              stateQ <= engPkg::CopyIdle;
            end else begin
              stateQ <= engPkg::CopyRead;
            end
          end
        end
        default: stateQ <= engPkg::CopyIdle;
      endcase
    end
  end

endmodule

//--- design/memArbiter.sv
`timescale 1ns/1ns
`include "scratch_defs.svh"

module memArbiter #(
  parameter int unsigned NumReq = 3
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // one lane per requester
  input  logic          [NumReq-1:0] req_i,
  input  logic          [NumReq-1:0] we_i,
  input  memPkg::addr_t [NumReq-1:0] addr_i,
  input  memPkg::data_t [NumReq-1:0] wdata_i,
  input  memPkg::be_t   [NumReq-1:0] be_i,
  output logic          [NumReq-1:0] gnt_o,
  output logic          [NumReq-1:0] rvalid_o,
  // toward the sram
  output logic                       memReq_o,
  output logic                       memWe_o,
  output memPkg::addr_t              memAddr_o,
  output memPkg::data_t              memWdata_o,
  output memPkg::be_t                memBe_o
);

  // read-valid delay matches the sram read latency
  localparam int unsigned Latency = `SCR_LATENCY;

  // slot with highest priority this cycle
  memPkg::reqIdx_t ptrQ;

  logic            winValid;
  memPkg::reqIdx_t winIdx;

  // in-flight reads, stage 0 is due this cycle
  logic            [Latency-1:0] vldQ;
  memPkg::reqIdx_t [Latency-1:0] idxQ;

  // rotating priority search starting at the pointer
  always_comb begin
    int unsigned cand;
    winValid = 1'b0;
    winIdx   = '0;
    for (int unsigned k = 0; k < NumReq; k++) begin
      cand = (ptrQ + k) % NumReq;
      if (!winValid && req_i[cand]) begin
        winValid = 1'b1;
        winIdx   = memPkg::reqIdx_t'(cand);
      end
    end
  end

  // one-hot grant to the winner only
  always_comb begin
    gnt_o = '0;
    if (winValid) begin
      gnt_o[winIdx] = 1'b1;
    end
  end

  // winner's fields go straight to the sram
  assign memReq_o   = winValid;
  assign memWe_o    = we_i[winIdx];
  assign memAddr_o  = addr_i[winIdx];
  assign memWdata_o = wdata_i[winIdx];
  assign memBe_o    = be_i[winIdx];

  // return the read pulse to whoever issued it
  always_comb begin
    rvalid_o = '0;
    if (vldQ[0]) begin
      rvalid_o[idxQ[0]] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptrQ <= '0;
      vldQ <= '0;
      idxQ <= '0;
    end else begin
      // slot after the winner gets first pick next time
      if (winValid) begin
        ptrQ <= (winIdx == NumReq - 1) ? '0 : memPkg::reqIdx_t'(winIdx + 1);
      end
      // shift every cycle so back-to-back reads overlap
      for (int unsigned j = 0; j + 1 < Latency; j++) begin
        vldQ[j] <= vldQ[j+1];
        idxQ[j] <= idxQ[j+1];
      end
      vldQ[Latency-1] <= winValid && !we_i[winIdx];
      idxQ[Latency-1] <= winIdx;
    end
  end

endmodule

//--- design/scratchSram.sv
`timescale 1ns/1ns

module scratchSram #(
  parameter int unsigned NumWords  = 256,
  parameter int unsigned DataWidth = 32,
  parameter int unsigned ByteWidth = 8,
  parameter int unsigned Latency   = 1
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          req_i,
  input  logic          we_i,
  input  memPkg::addr_t addr_i,
  input  memPkg::data_t wdata_i,
  input  memPkg::be_t   be_i,
  output memPkg::data_t rdata_o
);

  // storage array
  logic [DataWidth-1:0] mem [NumWords];

  // address of the most recent read keeps the output steady
  memPkg::addr_t rAddrQ;

  // read data pipeline with stage 0 driving the output
  logic [Latency-1:0][DataWidth-1:0] rdataQ;
  logic [DataWidth-1:0] rdataD;

  // a fresh read looks at the request address
  // otherwise keep presenting the last read word
  assign rdataD = (req_i && !we_i) ? mem[addr_i] : mem[rAddrQ];

  assign rdata_o = rdataQ[0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // array comes up as all zeros
      for (int unsigned i = 0; i < NumWords; i++) begin
        mem[i] <= '0;
      end
      rAddrQ <= '0;
      rdataQ <= '0;
    end else begin
      // advance the read pipeline before the array changes
      for (int unsigned j = 0; j + 1 < Latency; j++) begin
        rdataQ[j] <= rdataQ[j+1];
      end
      rdataQ[Latency-1] <= rdataD;

      if (req_i) begin
        if (we_i) begin
          // masked write where bit j belongs to lane j/ByteWidth
          for (int unsigned j = 0; j < DataWidth; j++) begin
            if (be_i[j/ByteWidth]) begin
              mem[addr_i][j] <= wdata_i[j];
            end
          end
        end else begin
          // remember read address for later idle cycles
          rAddrQ <= addr_i;
        end
      end
    end
  end

endmodule

//--- design/engPkg.sv
`include "scratch_defs.svh"

// engine-side types for the copy and fill engines
package engPkg;

  // run length in words
  // one extra bit so a run over the whole array fits
  typedef logic [$clog2(`SCR_NUM_WORDS):0] len_t;

  // copy engine fsm, one read then one write per word
  typedef enum logic [1:0] {
    CopyIdle,
    CopyRead,
    CopyWaitData,
    CopyWrite
  } copyState_t;

  // fill engine fsm, only ever writes
  typedef enum logic {
    FillIdle,
    FillWrite
  } fillState_t;

endpackage

//--- design/memPkg.sv
`include "scratch_defs.svh"

// memory-side types shared by the sram, the arbiter and the engines
package memPkg;

  // word address into the scratchpad
  typedef logic [$clog2(`SCR_NUM_WORDS)-1:0] addr_t;

  // one data word
  typedef logic [`SCR_DATA_WIDTH-1:0] data_t;

  // one enable bit per byte lane, rounded up
  typedef logic [(`SCR_DATA_WIDTH+`SCR_BYTE_WIDTH-1)/`SCR_BYTE_WIDTH-1:0] be_t;

  // requester slot number
  // host 0, copy 1, fill 2
  typedef logic [1:0] reqIdx_t;

endpackage

//--- design/scratch_defs.svh
`ifndef SCRATCH_DEFS_SVH
`define SCRATCH_DEFS_SVH

// scratchpad geometry

// number of sram words, address width follows from this
`define SCR_NUM_WORDS 256

// bits per data word
`define SCR_DATA_WIDTH 32

// bits covered by one byte-enable lane
`define SCR_BYTE_WIDTH 8

// cycles from granted read to valid read data
`define SCR_LATENCY 1

`endif
